// File: build.f
source/axi4s_pkg.sv
source/axi4s_if.sv
source/trunc_wb_regs.sv
source/axi4s_trunc.sv
source/axi4s_out_stage.sv
source/trunc_top.sv
testbench/tb_clock_gen.sv
testbench/tb_trunc_top.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the truncator testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_trunc_top \
    --Mdir obj_dir \
    -o tb_trunc_top \
    -f build.f

./obj_dir/tb_trunc_top > sim.log 2>&1 || true
cat sim.log

if grep -q -F "*** TEST PASSED ***" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// File: source/axi4s_if.sv
`timescale 1ns/1ns
`default_nettype none

interface axi4s_if;
    import axi4s_pkg::*;

    // Beat payload
    tdata_t tdata;
    tkeep_t tkeep;
    logic   tlast;
    tuser_t tuser;

    // Handshake
    logic   tvalid;
    logic   tready;

    // Source side drives the beat and holds it until accepted
    modport source (
        output tdata, tkeep, tlast, tuser, tvalid,
        input  tready
    );

    // Sink side only answers with tready
    modport sink (
        input  tdata, tkeep, tlast, tuser, tvalid,
        output tready
    );

endinterface

`default_nettype wire

// File: source/axi4s_out_stage.sv
`timescale 1ns/1ns
`default_nettype none

module axi4s_out_stage (
    input  wire     clk,
    input  wire     reset,
    axi4s_if.sink   in_if,
    axi4s_if.source out_if
);
    import axi4s_pkg::*;

    // Main entry faces the output, skid catches one beat on a stall
    logic   main_valid, skid_valid;
    tdata_t main_data, skid_data;
    tkeep_t main_keep, skid_keep;
    logic   main_last, skid_last;
    tuser_t main_user, skid_user;
    logic   in_fire, main_free;

    // Bytes without keep stored as zero
    function automatic tdata_t zero_unkept(input tdata_t d, input tkeep_t k);
        tdata_t r;
        for (int i = 0; i < DATA_BYTES; i++) begin
            r[i*8 +: 8] = k[i] ? d[i*8 +: 8] : 8'h00;
        end
        return r;
    endfunction

    // Registered ready, so one more beat lands after m_tready falls
    assign in_if.tready = !skid_valid;
    assign in_fire      = in_if.tvalid && in_if.tready;
    assign main_free    = !main_valid || out_if.tready;

    always_ff @(posedge clk) begin
        if (reset) begin
            main_valid <= 1'b0;
            main_data  <= '0;
            main_keep  <= '0;
            main_last  <= 1'b0;
            main_user  <= '0;
            skid_valid <= 1'b0;
            skid_data  <= '0;
            skid_keep  <= '0;
            skid_last  <= 1'b0;
            skid_user  <= '0;
        end else if (main_free) begin
            if (skid_valid) begin
                // Skid moves up, input is blocked this cycle
                main_valid <= 1'b1;
                {main_data, main_keep, main_last, main_user} <=
                    {skid_data, skid_keep, skid_last, skid_user};
                skid_valid <= 1'b0;
                {skid_data, skid_keep, skid_last, skid_user} <= '0;
            end else begin
                // Empty input also clears the entry to zeros
                main_valid <= in_fire;
                main_data  <= in_fire ? zero_unkept(in_if.tdata, in_if.tkeep) : '0;
                main_keep  <= in_fire ? in_if.tkeep : '0;
                main_last  <= in_fire && in_if.tlast;
                main_user  <= in_fire ? in_if.tuser : '0;
            end
        end else if (in_fire) begin
            skid_valid <= 1'b1;
            skid_data  <= zero_unkept(in_if.tdata, in_if.tkeep);
            skid_keep  <= in_if.tkeep;
            skid_last  <= in_if.tlast;
            skid_user  <= in_if.tuser;
        end
    end

    assign out_if.tvalid = main_valid;
    assign out_if.tdata  = main_data;
    assign out_if.tkeep  = main_keep;
    assign out_if.tlast  = main_last;
    assign out_if.tuser  = main_user;

    a_hold_stalled: assert property (@(posedge clk) disable iff (reset)
        out_if.tvalid && !out_if.tready |=> out_if.tvalid &&
        $stable(out_if.tdata) && $stable(out_if.tkeep) &&
        $stable(out_if.tlast) && $stable(out_if.tuser));

    a_idle_zero: assert property (@(posedge clk) disable iff (reset)
        !out_if.tvalid |-> (out_if.tdata == '0) && (out_if.tkeep == '0) &&
        !out_if.tlast && (out_if.tuser == '0));

endmodule

`default_nettype wire

// File: source/axi4s_pkg.sv
`default_nettype none

package axi4s_pkg;

    // ====================
    // Stream data path
    // ====================

    // Fixed 8-byte beat
    localparam int DATA_BYTES = 8;

    typedef logic [DATA_BYTES*8-1:0] tdata_t;
    typedef logic [DATA_BYTES-1:0]   tkeep_t;

    // Sideband carried unchanged with each beat
    typedef logic [3:0] tuser_t;

    // Truncation length in bytes, zero disables truncation
    typedef logic [15:0] pkt_len_t;

    // Count of packets that were shortened, wraps
    typedef logic [15:0] pkt_cnt_t;

    // ====================
    // Register port
    // ====================

    typedef logic [1:0]  wb_adr_t;
    typedef logic [15:0] wb_dat_t;

    // Read/write length register
    localparam wb_adr_t REG_LENGTH    = 2'd0;
    // Read-only truncated-packet counter
    localparam wb_adr_t REG_TRUNC_CNT = 2'd1;

    // ====================
    // Truncator FSM
    // ====================

    // SOP waits for first beat, PASS forwards, DROP discards the tail
    typedef enum logic [1:0] {
        SOP,
        PASS,
        DROP
    } trunc_state_e;

endpackage

`default_nettype wire

// File: source/axi4s_trunc.sv
`timescale 1ns/1ns
`default_nettype none

module axi4s_trunc (
    input  wire                 clk,
    input  wire                 reset,
    axi4s_if.sink               in_if,
    axi4s_if.source             out_if,
    input  axi4s_pkg::pkt_len_t trunc_len,
    output logic                trunc_event
);
    import axi4s_pkg::*;

    trunc_state_e state;
    pkt_len_t     len_q;
    pkt_len_t     byte_cnt;

    pkt_len_t     limit;
    pkt_len_t     cnt_before;
    pkt_len_t     remaining;
    logic [3:0]   beat_bytes;
    logic [$bits(pkt_len_t):0] byte_sum;
    logic         cut;
    logic         beat;

    // Bytes in a beat, keep is contiguous from byte 0
    function automatic logic [3:0] count_keep(input tkeep_t k);
        logic [3:0] n;
        n = '0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            n = n + {3'b000, k[i]};
        end
        return n;
    endfunction

    // Keep mask for the first n bytes
    function automatic tkeep_t keep_upto(input pkt_len_t n);
        tkeep_t m;
        m = '0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            if (pkt_len_t'(i) < n) begin
                m[i] = 1'b1;
            end
        end
        return m;
    endfunction

    // ====================
    // Byte accounting
    // ====================

    // First beat uses the live register, later beats the sampled copy
    assign limit      = (state == SOP) ? trunc_len : len_q;
    assign cnt_before = (state == SOP) ? '0 : byte_cnt;
    assign beat_bytes = count_keep(in_if.tkeep);
    assign byte_sum   = {1'b0, cnt_before} + {{($bits(pkt_len_t)-3){1'b0}}, beat_bytes};
    // Never zero while limited, DROP is entered at the limit
    assign remaining  = limit - cnt_before;

    // Limit hit with bytes still to come in this packet
    assign cut = (limit != '0) && (state != DROP) &&
                 ((byte_sum > {1'b0, limit}) ||
                  (byte_sum == {1'b0, limit} && !in_if.tlast));

    // ====================
    // Stream path
    // ====================

    // DROP drains the input regardless of downstream
    assign in_if.tready  = (state == DROP) ? 1'b1 : out_if.tready;
    assign beat          = in_if.tvalid && in_if.tready;

    assign out_if.tvalid = in_if.tvalid && (state != DROP);
    assign out_if.tdata  = in_if.tdata;
    assign out_if.tkeep  = cut ? (in_if.tkeep & keep_upto(remaining)) : in_if.tkeep;
    assign out_if.tlast  = in_if.tlast || cut;
    assign out_if.tuser  = in_if.tuser;

    assign trunc_event   = beat && cut;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= SOP;
            byte_cnt <= '0;
        end else if (beat) begin
            case (state)
                SOP, PASS: begin
                    byte_cnt <= pkt_len_t'(byte_sum);
                    if (cut && !in_if.tlast) begin
                        state <= DROP;
                    end else if (in_if.tlast) begin
                        state <= SOP;
                    end else begin
                        state <= PASS;
                    end
                end
                // Tail ends at the input tlast
                default: begin
                    if (in_if.tlast) begin
                        state <= SOP;
                    end
                end
            endcase
        end
    end

    // Length held for the rest of the packet
    always_ff @(posedge clk) begin
        if (beat && state == SOP) begin
            len_q <= trunc_len;
        end
    end

    // DROP only follows a cut beat that raised the event
    a_drop_after_cut: assert property (@(posedge clk) disable iff (reset)
        state == DROP && $past(state) != DROP |-> $past(trunc_event));

endmodule

`default_nettype wire

// File: source/trunc_top.sv
`timescale 1ns/1ns
`default_nettype none

module trunc_top (
    input  wire                 clk,
    input  wire                 reset,

    // Input stream
    input  axi4s_pkg::tdata_t   s_tdata,
    input  axi4s_pkg::tkeep_t   s_tkeep,
    input  wire                 s_tlast,
    input  axi4s_pkg::tuser_t   s_tuser,
    input  wire                 s_tvalid,
    output logic                s_tready,

    // Output stream
    output axi4s_pkg::tdata_t   m_tdata,
    output axi4s_pkg::tkeep_t   m_tkeep,
    output logic                m_tlast,
    output axi4s_pkg::tuser_t   m_tuser,
    output logic                m_tvalid,
    input  wire                 m_tready,

    // Register port
    input  wire                 wb_cyc,
    input  wire                 wb_stb,
    input  wire                 wb_we,
    input  axi4s_pkg::wb_adr_t  wb_adr,
    input  axi4s_pkg::wb_dat_t  wb_dat_w,
    output axi4s_pkg::wb_dat_t  wb_dat_r,
    output logic                wb_ack
);
    import axi4s_pkg::*;

    pkt_len_t trunc_len;
    logic     trunc_event;

    axi4s_if in_if ();
    axi4s_if trunc_if ();
    axi4s_if m_if ();

    // ====================
    // Port to stream
    // ====================
    assign in_if.tdata  = s_tdata;
    assign in_if.tkeep  = s_tkeep;
    assign in_if.tlast  = s_tlast;
    assign in_if.tuser  = s_tuser;
    assign in_if.tvalid = s_tvalid;
    assign s_tready     = in_if.tready;

    assign m_tdata      = m_if.tdata;
    assign m_tkeep      = m_if.tkeep;
    assign m_tlast      = m_if.tlast;
    assign m_tuser      = m_if.tuser;
    assign m_tvalid     = m_if.tvalid;
    assign m_if.tready  = m_tready;

    trunc_wb_regs u_regs (
        .clk         (clk),
        .reset       (reset),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .trunc_event (trunc_event),
        .trunc_len   (trunc_len)
    );

    // Combinational trimmer in front of the output registers
    axi4s_trunc u_trunc (
        .clk         (clk),
        .reset       (reset),
        .in_if       (in_if),
        .out_if      (trunc_if),
        .trunc_len   (trunc_len),
        .trunc_event (trunc_event)
    );

    axi4s_out_stage u_out_stage (
        .clk    (clk),
        .reset  (reset),
        .in_if  (trunc_if),
        .out_if (m_if)
    );

endmodule

`default_nettype wire

// File: source/trunc_wb_regs.sv
`timescale 1ns/1ns
`default_nettype none

module trunc_wb_regs (
    input  wire                 clk,
    input  wire                 reset,

    // Wishbone classic slave
    input  wire                 wb_cyc,
    input  wire                 wb_stb,
    input  wire                 wb_we,
    input  axi4s_pkg::wb_adr_t  wb_adr,
    input  axi4s_pkg::wb_dat_t  wb_dat_w,
    output axi4s_pkg::wb_dat_t  wb_dat_r,
    output logic                wb_ack,

    // One pulse per shortened packet
    input  wire                 trunc_event,

    // Length to the truncator
    output axi4s_pkg::pkt_len_t trunc_len
);
    import axi4s_pkg::*;

    pkt_len_t length_q;
    pkt_cnt_t trunc_cnt_q;
    logic     wb_req;

    // New request, ack not yet given
    assign wb_req = wb_cyc && wb_stb && !wb_ack;

    // ====================
    // Bus handshake
    // ====================

    // Ack one cycle after the request, one cycle wide
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_req;
        end
    end

    // Read data lines up with ack
    always_ff @(posedge clk) begin
        if (wb_req) begin
            case (wb_adr)
                REG_LENGTH:    wb_dat_r <= wb_dat_t'(length_q);
                REG_TRUNC_CNT: wb_dat_r <= wb_dat_t'(trunc_cnt_q);
                // Unmapped addresses read as zero
                default:       wb_dat_r <= '0;
            endcase
        end
    end

    // ====================
    // Registers
    // ====================

    always_ff @(posedge clk) begin
        if (reset) begin
            length_q <= '0;
        end else if (wb_req && wb_we && wb_adr == REG_LENGTH) begin
            length_q <= pkt_len_t'(wb_dat_w);
        end
    end

    // Wrapping count, bus writes ignored
    always_ff @(posedge clk) begin
        if (reset) begin
            trunc_cnt_q <= '0;
        end else if (trunc_event) begin
            trunc_cnt_q <= trunc_cnt_q + pkt_cnt_t'(1);
        end
    end

    // Truncator picks this up at its next SOP
    assign trunc_len = length_q;

    // Classic cycle never sees a stretched ack
    a_ack_single: assert property (@(posedge clk) disable iff (reset)
        wb_ack |=> !wb_ack);

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);
    // 4 ns period
    localparam int HALF_PERIOD_NS = 2;
    localparam int RESET_CYCLES   = 16;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

    // Reset released on a falling edge, away from the sampling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// File: testbench/tb_trunc_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_trunc_top;
    import axi4s_pkg::*;

    // One expected output beat
    typedef struct packed {
        tdata_t data;
        tkeep_t keep;
        logic   last;
        tuser_t user;
    } beat_t;

    // 90 packets of at most 5 beats, 20 cycles per beat at 4 ns
    localparam int TOTAL_BEATS = 90 * 5;
    localparam int WATCHDOG_NS = TOTAL_BEATS * 20 * 4;

    logic        clk;
    logic        reset;
    tdata_t      s_tdata;
    tkeep_t      s_tkeep;
    tuser_t      s_tuser;
    logic        s_tlast;
    logic        s_tvalid;
    logic        s_tready;
    tdata_t      m_tdata;
    tkeep_t      m_tkeep;
    tuser_t      m_tuser;
    logic        m_tlast;
    logic        m_tvalid;
    logic        m_tready;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic        wb_ack;
    wb_adr_t     wb_adr;
    wb_dat_t     wb_dat_w;
    wb_dat_t     wb_dat_r;

    // Reference FIFO, written by stimulus and read at the output
    beat_t       exp_ring [0:1023];
    beat_t       exp_head;
    logic [9:0]  wr_ptr = '0;
    logic [9:0]  rd_ptr = '0;

    logic [15:0] lfsr = 16'd7;
    logic        stall_on = 1'b0;
    int          check_errs = 0;
    int          mon_errs = 0;
    int          zero_errs = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          trunc_expected = 0;
    int          cur_len = 0;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    trunc_top u_trunc_top (
        .clk      (clk),
        .reset    (reset),
        .s_tdata  (s_tdata),
        .s_tkeep  (s_tkeep),
        .s_tlast  (s_tlast),
        .s_tuser  (s_tuser),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .m_tdata  (m_tdata),
        .m_tkeep  (m_tkeep),
        .m_tlast  (m_tlast),
        .m_tuser  (m_tuser),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    // ====================
    // Helpers
    // ====================

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // Keep for the first n bytes
    function automatic tkeep_t byte_keep(input int n);
        tkeep_t k;
        for (int i = 0; i < DATA_BYTES; i++) begin
            k[i] = (i < n);
        end
        return k;
    endfunction

    // Keep widened to a data mask
    function automatic tdata_t byte_mask(input tkeep_t k);
        tdata_t m;
        for (int i = 0; i < DATA_BYTES; i++) begin
            m[i*8 +: 8] = {8{k[i]}};
        end
        return m;
    endfunction

    function automatic int error_total();
        return check_errs + mon_errs + zero_errs;
    endfunction

    // One LFSR step per bit
    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[62:0], lfsr[0]};
        end
    endtask

    // Next falling edge, where m_tready may change
    task automatic tick();
        logic [63:0] bits;
        @(negedge clk);
        if (stall_on) begin
            take_bits(2, bits);
            // Ready three cycles in four
            m_tready = (bits[1:0] != 2'b00);
        end else begin
            m_tready = 1'b1;
        end
    endtask

    task automatic push_expected(input beat_t b);
        exp_ring[wr_ptr] = b;
        wr_ptr = wr_ptr + 10'd1;
    endtask

    // Classic cycle, ack expected exactly one cycle after the request
    task automatic bus_cycle(input wb_adr_t adr, input logic we, input wb_dat_t wdat,
                             output wb_dat_t rdat);
        int waited;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        waited   = 0;
        do begin
            tick();
            waited++;
        end while (!wb_ack && waited < 16);
        assert (waited == 1 && wb_ack) else begin
            $display("Wishbone ack missing or late at %0t, %0d cycles", $time, waited);
            check_errs++;
        end
        rdat   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        tick();
        assert (!wb_ack) else begin
            $display("Wishbone ack held longer than one cycle at %0t", $time);
            check_errs++;
        end
    endtask

    task automatic write_reg(input wb_adr_t adr, input wb_dat_t data);
        wb_dat_t ignored;
        bus_cycle(adr, 1'b1, data, ignored);
        if (adr == REG_LENGTH) begin
            cur_len = int'(data);
        end
    endtask

    task automatic read_check(input wb_adr_t adr, input wb_dat_t expected);
        wb_dat_t got;
        bus_cycle(adr, 1'b0, '0, got);
        assert (got == expected) else begin
            $display("Mismatch at %0t: wb_dat_r (adr %0d) expected %h got %h",
                     $time, adr, expected, got);
            check_errs++;
        end
    endtask

    // Drives one packet and queues the beats the truncation rule keeps
    task automatic send_packet(input int size);
        int          kept;
        int          nbeats;
        int          start;
        int          n;
        int          out_n;
        int          waited;
        logic        taken;
        logic [63:0] bits;
        tuser_t      user;
        beat_t       exp;
        kept = (cur_len == 0 || size < cur_len) ? size : cur_len;
        if (size > kept) begin
            trunc_expected++;
        end
        take_bits(4, bits);
        user   = bits[3:0];
        nbeats = (size + 7) / 8;
        for (int b = 0; b < nbeats; b++) begin
            start = b * 8;
            n     = (size - start > 8) ? 8 : size - start;
            take_bits(64, bits);
            // Beats past the last kept byte are dropped
            if (start < kept) begin
                out_n    = (kept - start > n) ? n : kept - start;
                exp.keep = byte_keep(out_n);
                exp.data = bits & byte_mask(exp.keep);
                exp.last = (start + n >= kept);
                exp.user = user;
                push_expected(exp);
            end
            s_tdata  = bits;
            s_tkeep  = byte_keep(n);
            s_tlast  = (b == nbeats - 1);
            s_tuser  = user;
            s_tvalid = 1'b1;
            waited   = 0;
            taken    = 1'b0;
            // Ready is stable between edges, sampled ahead of the rising edge
            while (!taken && waited < 200) begin
                taken = s_tready;
                @(posedge clk);
                tick();
                waited++;
            end
            assert (taken) else begin
                $display("Input beat never accepted at %0t", $time);
                check_errs++;
            end
        end
        s_tvalid = 1'b0;
        s_tdata  = '0;
        s_tkeep  = '0;
        s_tlast  = 1'b0;
        s_tuser  = '0;
    endtask

    // Sizes 1 to 40 bytes
    task automatic send_random(input int count);
        logic [63:0] bits;
        for (int i = 0; i < count; i++) begin
            take_bits(6, bits);
            send_packet(int'(bits[5:0]) % 40 + 1);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (rd_ptr != wr_ptr && waited < 1000) begin
            tick();
            waited++;
        end
        assert (rd_ptr == wr_ptr) else begin
            $display("Output stalled with %0d beats still expected", wr_ptr - rd_ptr);
            check_errs++;
        end
        // Room for a stray beat to show
        repeat (4) tick();
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (error_total() == errs_before) begin
            tests_passed++;
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed, %0d errors", name, error_total() - errs_before);
        end
    endtask

    // ====================
    // Output checks
    // ====================

    assign exp_head = exp_ring[rd_ptr];

    // Head moves on each accepted output beat
    always @(posedge clk) begin
        if (!reset && m_tvalid && m_tready) begin
            rd_ptr <= rd_ptr + 10'd1;
        end
    end

    a_no_extra_beat: assert property (@(posedge clk) disable iff (reset)
        m_tvalid |-> rd_ptr != wr_ptr)
        else begin
            $display("Output beat at %0t with none expected", $time);
            mon_errs++;
        end

    a_tdata: assert property (@(posedge clk) disable iff (reset)
        m_tvalid && rd_ptr != wr_ptr |-> m_tdata == exp_head.data)
        else begin
            $display("Mismatch at %0t: m_tdata expected %h got %h", $time,
                     $sampled(exp_head.data), $sampled(m_tdata));
            mon_errs++;
        end

    a_tkeep: assert property (@(posedge clk) disable iff (reset)
        m_tvalid && rd_ptr != wr_ptr |-> m_tkeep == exp_head.keep)
        else begin
            $display("Mismatch at %0t: m_tkeep expected %h got %h", $time,
                     $sampled(exp_head.keep), $sampled(m_tkeep));
            mon_errs++;
        end

    a_tlast: assert property (@(posedge clk) disable iff (reset)
        m_tvalid && rd_ptr != wr_ptr |-> m_tlast == exp_head.last)
        else begin
            $display("Mismatch at %0t: m_tlast expected %b got %b", $time,
                     $sampled(exp_head.last), $sampled(m_tlast));
            mon_errs++;
        end

    a_tuser: assert property (@(posedge clk) disable iff (reset)
        m_tvalid && rd_ptr != wr_ptr |-> m_tuser == exp_head.user)
        else begin
            $display("Mismatch at %0t: m_tuser expected %h got %h", $time,
                     $sampled(exp_head.user), $sampled(m_tuser));
            mon_errs++;
        end

    // Unkept bytes and idle outputs carry zeros
    a_unkept_zero: assert property (@(posedge clk) disable iff (reset)
        m_tvalid |-> (m_tdata & ~byte_mask(m_tkeep)) == '0)
        else begin
            $display("Nonzero data in unkept bytes at %0t", $time);
            zero_errs++;
        end

    a_idle_zero: assert property (@(posedge clk) disable iff (reset)
        !m_tvalid |-> m_tdata == '0 && m_tkeep == '0 && !m_tlast && m_tuser == '0)
        else begin
            $display("Output fields nonzero while m_tvalid low at %0t", $time);
            zero_errs++;
        end

    a_ack_pulse: assert property (@(posedge clk) disable iff (reset)
        wb_ack |=> !wb_ack)
        else begin
            $display("Wishbone ack high two cycles in a row at %0t", $time);
            mon_errs++;
        end

    // ====================
    // Test sequence
    // ====================

    initial begin
        int errs;
        s_tdata  = '0;
        s_tkeep  = '0;
        s_tlast  = 1'b0;
        s_tuser  = '0;
        s_tvalid = 1'b0;
        m_tready = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        @(negedge reset);
        tick();

        errs = error_total();
        read_check(REG_TRUNC_CNT, 16'd0);
        write_reg(REG_LENGTH, 16'h00a5);
        read_check(REG_LENGTH, 16'h00a5);
        // Unmapped address
        read_check(2'd3, 16'd0);
        write_reg(REG_LENGTH, 16'd0);
        end_test("register access", errs);

        errs = error_total();
        send_random(30);
        wait_drain();
        end_test("pass-through", errs);

        // Edge sizes around the limit, then random ones
        errs = error_total();
        write_reg(REG_LENGTH, 16'd13);
        send_packet(13);
        send_packet(14);
        send_packet(16);
        send_packet(8);
        send_packet(40);
        send_random(25);
        wait_drain();
        end_test("truncation", errs);

        errs = error_total();
        read_check(REG_TRUNC_CNT, wb_dat_t'(trunc_expected));
        end_test("counter", errs);

        errs = error_total();
        write_reg(REG_LENGTH, 16'd21);
        stall_on = 1'b1;
        send_random(30);
        wait_drain();
        stall_on = 1'b0;
        end_test("back-pressure", errs);

        // Zeroing checks ran on every cycle above
        if (zero_errs == 0) begin
            tests_passed++;
            $display("Test zeroing: passed");
        end else begin
            tests_failed++;
            $display("Test zeroing: failed, %0d errors", zero_errs);
        end

        $display("Tests passed: %0d, failed: %0d, errors: %0d",
                 tests_passed, tests_failed, error_total());
        if (tests_failed == 0 && error_total() == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: simulation did not finish within %0d ns", WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
